// File: renkon_pool_pkg.sv
package renkon_pool_pkg;

  localparam int DWIDTH     = 16;               // signed feature pixel
  localparam int LWIDTH     = 8;                // sizes and position counters
  localparam int MAX_FEA    = 32;               // largest feature edge, sets the line buffer depth
  localparam int POOL_K     = 2;                // kernel edge
  localparam int D_POOLBUF  = 1;                // control stages matching the line buffer
  localparam int D_POOL     = 2;                // control stages matching the comparator tree
  localparam int BUF_AWIDTH = $clog2(MAX_FEA);  // line buffer address

  typedef logic signed [DWIDTH-1:0] pixel_t;

  // 2x2 window, index 0 is the upper-left pixel, then upper-right,
  // lower-left and lower-right
  typedef pixel_t [0:POOL_K*POOL_K-1] pool_window_t;

  typedef enum logic {
    S_WAIT,
    S_ACTIVE
  } ctrl_state_t;

  // one stage of the control delay line
  typedef struct packed {
    logic start;
    logic valid;
    logic stop;
  } ctrl_strobe_t;

endpackage

// File: pool_ctrl_if.sv
// delayed frame strobes from the pooling controller to the max unit
interface pool_ctrl_if;

  logic start;  // first pooled pixel of a frame
  logic valid;  // pooled pixel present on the output
  logic stop;   // last pooled pixel of a frame
  logic oe;     // loads the output register, one cycle ahead of valid

  modport master (
    output start,
    output valid,
    output stop,
    output oe
  );

  modport slave (
    input start,
    input valid,
    input stop,
    input oe
  );

endinterface

// File: renkon_ctrl_pool.sv
module renkon_ctrl_pool
  import renkon_pool_pkg::*;
(
  input  logic              clk,
  input  logic              xrst,
  input  logic              in_start,
  input  logic              in_valid,
  input  logic [LWIDTH-1:0] fea_size,
  input  logic [LWIDTH-1:0] pool_size,
  output logic              buf_clear,
  output logic [LWIDTH-1:0] w_fea_size,
  pool_ctrl_if.master       ctrl
);

  localparam int N_DLY = D_POOLBUF + D_POOL;

  ctrl_state_t       state;
  logic [LWIDTH-1:0] fea_size_r;
  logic [LWIDTH-1:0] pool_size_r;
  logic [LWIDTH-1:0] pos_x;
  logic [LWIDTH-1:0] pos_y;
  logic [LWIDTH-1:0] phase_x;
  logic [LWIDTH-1:0] phase_y;
  logic              take;
  logic              row_end;
  logic              col_end;
  ctrl_strobe_t      first;
  ctrl_strobe_t      dly [N_DLY];

  assign w_fea_size = fea_size_r;

  // a frame stays active until its stop strobe leaves the max unit
  always_ff @(posedge clk) begin
    if (!xrst) begin
      state <= S_WAIT;
    end else begin
      case (state)
        S_WAIT:   if (in_start) state <= S_ACTIVE;
        S_ACTIVE: if (dly[N_DLY-1].stop) state <= S_WAIT;
        default:  state <= S_WAIT;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      fea_size_r  <= '0;
      pool_size_r <= '0;
      buf_clear   <= 1'b0;
    end else begin
      buf_clear <= in_start && state == S_WAIT;  // line buffer restarts its column pointer
      if (in_start && state == S_WAIT) begin
        fea_size_r  <= fea_size;
        pool_size_r <= pool_size;
      end
    end
  end

  assign take    = state == S_ACTIVE && in_valid;
  assign row_end = pos_x == fea_size_r - 1'b1;
  assign col_end = pos_y == fea_size_r - 1'b1;

  // position and stride phase of the pixel presented in this cycle
  always_ff @(posedge clk) begin
    if (!xrst || state == S_WAIT) begin
      pos_x   <= '0;
      pos_y   <= '0;
      phase_x <= '0;
      phase_y <= '0;
    end else if (take) begin
      pos_x   <= row_end ? '0 : pos_x + 1'b1;
      phase_x <= (phase_x == pool_size_r - 1'b1) ? '0 : phase_x + 1'b1;
      if (row_end) begin
        pos_y   <= col_end ? '0 : pos_y + 1'b1;
        phase_y <= (phase_y == pool_size_r - 1'b1) ? '0 : phase_y + 1'b1;
      end
    end
  end

  // a window completes on a stride boundary once a full row and column are in
  always_comb begin
    first.valid = take && pos_x != '0 && pos_y != '0
                  && phase_x == pool_size_r - 1'b1
                  && phase_y == pool_size_r - 1'b1;
    first.start = first.valid && pos_x == LWIDTH'(1) && pos_y == LWIDTH'(1);
    first.stop  = first.valid && row_end && col_end;
  end

  // stage D_POOLBUF-1 lines up with the window, the last one with out_pixel
  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int i = 0; i < N_DLY; i++) begin
        dly[i] <= '0;
      end
    end else begin
      dly[0] <= first;
      for (int i = 1; i < N_DLY; i++) begin
        dly[i] <= dly[i-1];
      end
    end
  end

  assign ctrl.start = dly[N_DLY-1].start;
  assign ctrl.valid = dly[N_DLY-1].valid;
  assign ctrl.stop  = dly[N_DLY-1].stop;
  assign ctrl.oe    = dly[N_DLY-2].valid;  // output register loads one cycle early

  a_pool_size: assert property (
    @(posedge clk) disable iff (!xrst)
    (in_start && state == S_WAIT) |-> (pool_size == LWIDTH'(1) || pool_size == LWIDTH'(2))
  );

  // a new frame may only start once the previous stop has drained
  a_start_idle: assert property (
    @(posedge clk) disable iff (!xrst)
    state == S_ACTIVE |-> !in_start
  );

endmodule

// File: renkon_pool_buf.sv
module renkon_pool_buf
  import renkon_pool_pkg::*;
(
  input  logic                     clk,
  input  logic                     xrst,
  input  logic                     buf_clear,
  input  logic                     in_valid,
  input  logic signed [DWIDTH-1:0] in_pixel,
  input  logic [LWIDTH-1:0]        w_fea_size,
  output pool_window_t             win
);

  pixel_t                line_mem [MAX_FEA];  // previous row, one entry per column
  logic [LWIDTH-1:0]     col_ptr;
  logic [LWIDTH-1:0]     col;
  logic [BUF_AWIDTH-1:0] addr;
  pixel_t                above;       // pixel of the row above, same column
  pixel_t                prev_above;  // row above, previous column
  pixel_t                prev_cur;    // current row, previous column

  // the clear pulse may coincide with the first pixel of a frame
  assign col   = buf_clear ? '0 : col_ptr;
  assign addr  = col[BUF_AWIDTH-1:0];
  assign above = line_mem[addr];

  always_ff @(posedge clk) begin
    if (!xrst) begin
      col_ptr <= '0;
    end else if (in_valid) begin
      col_ptr <= (col == w_fea_size - 1'b1) ? '0 : col + 1'b1;
    end else if (buf_clear) begin
      col_ptr <= '0;
    end
  end

  // the old entry is read before the new pixel replaces it
  always_ff @(posedge clk) begin
    if (in_valid) begin
      line_mem[addr] <= in_pixel;
      prev_above     <= above;
      prev_cur       <= in_pixel;
      win            <= {prev_above, above, prev_cur, in_pixel};
    end
  end

  a_fea_depth: assert property (
    @(posedge clk) disable iff (!xrst)
    w_fea_size <= LWIDTH'(MAX_FEA)
  );

endmodule

// File: renkon_pool_max.sv
module renkon_pool_max
  import renkon_pool_pkg::*;
(
  input  logic                     clk,
  input  logic                     xrst,
  input  pool_window_t             win,
  pool_ctrl_if.slave               ctrl,
  output logic                     out_start,
  output logic                     out_valid,
  output logic                     out_stop,
  output logic signed [DWIDTH-1:0] out_pixel
);

  pixel_t max_top;  // larger of the upper pair
  pixel_t max_bot;  // larger of the lower pair

  function automatic pixel_t max2(input pixel_t a, input pixel_t b);
    return (a > b) ? a : b;
  endfunction

  // first level of the tree follows the window every cycle
  always_ff @(posedge clk) begin
    max_top <= max2(win[0], win[1]);
    max_bot <= max2(win[2], win[3]);
  end

  // second level only updates for a pooled position, so the value holds between outputs
  always_ff @(posedge clk) begin
    if (ctrl.oe) begin
      out_pixel <= max2(max_top, max_bot);
    end
  end

  assign out_start = ctrl.start;
  assign out_valid = ctrl.valid;
  assign out_stop  = ctrl.stop;

  a_stop_valid: assert property (
    @(posedge clk) disable iff (!xrst)
    out_stop |-> out_valid
  );

endmodule

// File: renkon_pool.sv
module renkon_pool
  import renkon_pool_pkg::*;
(
  input  logic                     clk,
  input  logic                     xrst,
  input  logic                     in_start,
  input  logic                     in_valid,
  input  logic signed [DWIDTH-1:0] in_pixel,
  input  logic [LWIDTH-1:0]        fea_size,
  input  logic [LWIDTH-1:0]        pool_size,
  output logic                     out_start,
  output logic                     out_valid,
  output logic                     out_stop,
  output logic signed [DWIDTH-1:0] out_pixel
);

  logic              buf_clear;
  logic [LWIDTH-1:0] w_fea_size;
  pool_window_t      win;

  pool_ctrl_if pool_ctrl ();

  // counts positions and times the strobes
  renkon_ctrl_pool ctrl_pool (
    .clk        (clk),
    .xrst       (xrst),
    .in_start   (in_start),
    .in_valid   (in_valid),
    .fea_size   (fea_size),
    .pool_size  (pool_size),
    .buf_clear  (buf_clear),
    .w_fea_size (w_fea_size),
    .ctrl       (pool_ctrl.master)
  );

  renkon_pool_buf pool_buf (
    .clk        (clk),
    .xrst       (xrst),
    .buf_clear  (buf_clear),
    .in_valid   (in_valid),
    .in_pixel   (in_pixel),
    .w_fea_size (w_fea_size),
    .win        (win)
  );

  renkon_pool_max pool_max (
    .clk        (clk),
    .xrst       (xrst),
    .win        (win),
    .ctrl       (pool_ctrl.slave),
    .out_start  (out_start),
    .out_valid  (out_valid),
    .out_stop   (out_stop),
    .out_pixel  (out_pixel)
  );

endmodule

// File: tb_renkon_pool_tasks.svh
`ifndef TB_RENKON_POOL_TASKS_SVH
`define TB_RENKON_POOL_TASKS_SVH

// random signed pixels, or only negative ones with the sign bit forced
task automatic fill_frame(input int n, input bit negative);
  logic [31:0] r;
  for (int y = 0; y < n; y++) begin
    for (int x = 0; x < n; x++) begin
      r = $random(seed);
      frame[y][x] = negative ? {1'b1, r[DWIDTH-2:0]} : r[DWIDTH-1:0];
    end
  end
endtask

task automatic drive_frame(input int n, input int s, input bit gaps);
  int idle;
  @(posedge clk);
  #DRV;
  in_start  = 1'b1;
  fea_size  = LWIDTH'(n);
  pool_size = LWIDTH'(s);
  @(posedge clk);
  #DRV;
  in_start = 1'b0;
  for (int y = 0; y < n; y++) begin
    for (int x = 0; x < n; x++) begin
      in_valid = 1'b1;
      in_pixel = frame[y][x];
      if (completes_window(x, y, s)) exp_cycle.push_back(cycle_cnt + 3);
      @(posedge clk);
      #DRV;
      in_valid = 1'b0;
      // idle cycles only between pixels, the last one is followed by the drain
      if (gaps && !(x == n - 1 && y == n - 1)) begin
        idle = $random(seed) & 3;  // up to three idle cycles
        repeat (idle) begin
          @(posedge clk);
          #DRV;
        end
      end
    end
  end
endtask

// the FSM is idle again in the cycle after out_stop
task automatic wait_frame_end();
  int  n;
  bit  seen;
  n    = 0;
  seen = 1'b0;
  while (!seen && n < WAIT_LIMIT) begin
    @(negedge clk);
    seen = out_stop;
    n++;
  end
  if (!seen) begin
    timeouts++;
    $display("timeout: no out_stop within %0d cycles at time %0t", WAIT_LIMIT, $time);
  end else begin
    @(posedge clk);
    #DRV;
    assert (exp_pixel.size() == 0) else begin
      proto_errors++;
      $display("frame ended at time %0t with %0d outputs missing", $time, exp_pixel.size());
    end
  end
endtask

task automatic run_frame(input int n, input int s, input bit negative, input bit gaps);
  fill_frame(n, negative);
  build_expected(n, s);
  drive_frame(n, s, gaps);
  wait_frame_end();
endtask

task automatic idle_after_reset();
  repeat (20) begin
    @(negedge clk);
    assert (!out_start && !out_valid && !out_stop) else begin
      proto_errors++;
      $display("output strobe active at time %0t with no input", $time);
    end
  end
endtask

task automatic stride2_random_frame();
  run_frame(4, 2, 1'b0, 1'b0);
endtask

task automatic stride1_random_frame();
  run_frame(4, 1, 1'b0, 1'b0);
endtask

task automatic negative_frame_with_gaps();
  run_frame(6, 2, 1'b1, 1'b1);
endtask

// the second frame starts right after the first one drains
task automatic back_to_back_frames();
  run_frame(4, 2, 1'b0, 1'b0);
  if (timeouts == 0) run_frame(8, 1, 1'b0, 1'b0);
endtask

`endif

// File: tb_renkon_pool.sv
module tb_renkon_pool
  import renkon_pool_pkg::*;
;

  localparam int DRV        = 2;    // input drive delay after the rising edge
  localparam int WAIT_LIMIT = 400;  // cycles allowed for a frame to drain

  logic              clk;
  logic              xrst;
  logic              in_start;
  logic              in_valid;
  pixel_t            in_pixel;
  logic [LWIDTH-1:0] fea_size;
  logic [LWIDTH-1:0] pool_size;
  logic              out_start;
  logic              out_valid;
  logic              out_stop;
  pixel_t            out_pixel;

  integer seed;
  int     cycle_cnt;
  int     value_errors;
  int     proto_errors;
  int     timeouts;

  pixel_t frame [MAX_FEA][MAX_FEA];  // current input frame, indexed [y][x]
  pixel_t exp_pixel[$];
  bit     exp_first[$];
  bit     exp_last[$];
  int     exp_cycle[$];              // cycle in which each output is due

  pixel_t e_pix;
  bit     e_first;
  bit     e_last;
  int     e_cycle;

  renkon_pool DUT (
    .clk       (clk),
    .xrst      (xrst),
    .in_start  (in_start),
    .in_valid  (in_valid),
    .in_pixel  (in_pixel),
    .fea_size  (fea_size),
    .pool_size (pool_size),
    .out_start (out_start),
    .out_valid (out_valid),
    .out_stop  (out_stop),
    .out_pixel (out_pixel)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  // a pixel ends a pooled window once it closes a stride step in both directions
  function automatic bit completes_window(input int x, input int y, input int s);
    return x >= 1 && y >= 1 && (x % s) == s - 1 && (y % s) == s - 1;
  endfunction

  function automatic pixel_t window_max(input int x, input int y);
    pixel_t m;
    m = frame[y-1][x-1];
    if (frame[y-1][x] > m) m = frame[y-1][x];
    if (frame[y][x-1] > m) m = frame[y][x-1];
    if (frame[y][x] > m) m = frame[y][x];
    return m;
  endfunction

  // expected outputs of an n x n frame at stride s, in row-major order
  task automatic build_expected(input int n, input int s);
    bit first;
    first = 1'b1;
    for (int y = 0; y < n; y++) begin
      for (int x = 0; x < n; x++) begin
        if (completes_window(x, y, s)) begin
          exp_pixel.push_back(window_max(x, y));
          exp_first.push_back(first);
          exp_last.push_back(1'b0);
          first = 1'b0;
        end
      end
    end
    exp_last[exp_last.size()-1] = 1'b1;
  endtask

  // outputs are stable in the middle of the cycle
  always @(negedge clk) begin
    if (xrst) begin
      assert (out_valid || !out_start) else begin
        proto_errors++;
        $display("out_start at time %0t came without out_valid", $time);
      end
      assert (out_valid || !out_stop) else begin
        proto_errors++;
        $display("out_stop at time %0t came without out_valid", $time);
      end
      if (out_valid) begin
        assert (exp_pixel.size() != 0 && exp_cycle.size() != 0) else begin
          proto_errors++;
          $display("out_valid at time %0t with no output expected", $time);
        end
        if (exp_pixel.size() != 0 && exp_cycle.size() != 0) begin
          e_pix   = exp_pixel.pop_front();
          e_first = exp_first.pop_front();
          e_last  = exp_last.pop_front();
          e_cycle = exp_cycle.pop_front();
          assert (out_pixel === e_pix) else begin
            value_errors++;
            $display("Fail time=%0t signal=out_pixel expected=%0d actual=%0d",
                     $time, e_pix, out_pixel);
          end
          assert (out_start === e_first) else begin
            value_errors++;
            $display("Fail time=%0t signal=out_start expected=%0b actual=%0b",
                     $time, e_first, out_start);
          end
          assert (out_stop === e_last) else begin
            value_errors++;
            $display("Fail time=%0t signal=out_stop expected=%0b actual=%0b",
                     $time, e_last, out_stop);
          end
          assert (cycle_cnt == e_cycle) else begin  // latency from the closing pixel
            value_errors++;
            $display("Fail time=%0t signal=out_valid cycle expected=%0d actual=%0d",
                     $time, e_cycle, cycle_cnt);
          end
        end
      end
    end
  end

  `include "tb_renkon_pool_tasks.svh"

  initial begin
    seed         = 32'h2fd6;
    value_errors = 0;
    proto_errors = 0;
    timeouts     = 0;
    xrst         = 1'b0;
    in_start     = 1'b0;
    in_valid     = 1'b0;
    in_pixel     = '0;
    fea_size     = '0;
    pool_size    = '0;
    repeat (4) @(posedge clk);
    #DRV;
    xrst = 1'b1;

    idle_after_reset();
    if (timeouts == 0) stride2_random_frame();
    if (timeouts == 0) stride1_random_frame();
    if (timeouts == 0) negative_frame_with_gaps();
    if (timeouts == 0) back_to_back_frames();

    $display("errors: value %0d, protocol %0d, timeout %0d",
             value_errors, proto_errors, timeouts);
    if (value_errors + proto_errors + timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: renkon_pool.f
+incdir+.
renkon_pool_pkg.sv
pool_ctrl_if.sv
renkon_ctrl_pool.sv
renkon_pool_buf.sv
renkon_pool_max.sv
renkon_pool.sv
tb_renkon_pool.sv

// File: run.sh
#!/bin/sh
# build and run the pooling stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f renkon_pool.f \
  --top-module tb_renkon_pool -o sim_renkon_pool
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_renkon_pool > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
  exit 1
fi
exit 0
